// ==== rtl/gpu_eu_pkg.sv ====
// ######################################
// Shared widths, vector types and the opcode enum
// for the compute unit execution cluster
// ######################################

`default_nettype none

package gpu_eu_pkg;

    // ######################################
    // Sizes
    // ######################################

    // Threads per warp
    localparam int unsigned WARP_WIDTH      = 4;
    // Bits per thread register
    localparam int unsigned REG_WIDTH       = 32;
    // Warps per compute unit
    localparam int unsigned NUM_WARPS       = 8;
    localparam int unsigned WID_WIDTH       = 3;
    // In-flight tag per warp
    localparam int unsigned TAG_WIDTH       = 3;
    // Destination register index
    localparam int unsigned REG_IDX_WIDTH   = 8;
    localparam int unsigned TBLOCK_IDX_BITS = 4;
    // Multiplier pipeline depth
    localparam int unsigned MUL_STAGES      = 3;

    // ######################################
    // Vector types
    // ######################################

    typedef logic [REG_WIDTH-1:0]              reg_data_t;
    // Thread i in bits REG_WIDTH*i and up
    typedef logic [WARP_WIDTH*REG_WIDTH-1:0]   warp_data_t;
    // Tag in the upper bits, warp id in the lower bits
    typedef logic [TAG_WIDTH+WID_WIDTH-1:0]    iid_t;
    typedef logic [REG_IDX_WIDTH-1:0]          reg_idx_t;
    typedef logic [WARP_WIDTH-1:0]             act_mask_t;
    typedef logic [TBLOCK_IDX_BITS-1:0]        tblock_idx_t;

    // ######################################
    // Opcodes
    // ######################################

    typedef enum logic [4:0] {
        // Identity queries
        EU_TID, EU_WID, EU_BID, EU_TBID,
        // Arithmetic
        EU_ADD, EU_ADDI, EU_SUB, EU_SUBI,
        // Logic and load immediate
        EU_LDI, EU_OR, EU_AND, EU_XOR,
        EU_SHL, EU_SHLI,
        // Served by the multiplier
        EU_MUL, EU_MULHU
    } eu_op_e;

endpackage : gpu_eu_pkg

`default_nettype wire

// ==== rtl/eu_dispatch.sv ====
// ######################################
// Issue steering to the integer and multiply units
// plus the per-warp thread-block index table
// ######################################

`default_nettype none

module eu_dispatch import gpu_eu_pkg::*; (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,

    // Table configuration
    input  wire logic                 cfg_we_i,
    input  wire logic [WID_WIDTH-1:0] cfg_wid_i,
    input  wire tblock_idx_t          cfg_tblock_idx_i,

    // Issue stream control
    input  wire logic                 in_valid_i,
    input  wire iid_t                 in_iid_i,
    input  wire eu_op_e               in_op_i,
    output logic                      in_ready_o,

    // Integer unit side
    output logic                      iu_valid_o,
    output tblock_idx_t               iu_tblock_idx_o,
    input  wire logic                 iu_ready_i,

    // Multiply unit side
    output logic                      mu_valid_o,
    input  wire logic                 mu_ready_i
);

    // ######################################
    // Thread-block index table
    // ######################################

    tblock_idx_t tbl_q [NUM_WARPS];

    // One entry written per cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                tbl_q[w] <= '0;
            end
        end else if (cfg_we_i) begin
            tbl_q[cfg_wid_i] <= cfg_tblock_idx_i;
        end
    end

    // Warp id lives in the low iid bits
    assign iu_tblock_idx_o = tbl_q[in_iid_i[WID_WIDTH-1:0]];

    // ######################################
    // Opcode class and steering
    // ######################################

    logic is_mul;

    // Only the two product ops use the multiplier
    assign is_mul = (in_op_i == EU_MUL) || (in_op_i == EU_MULHU);

    // Exactly one unit sees valid
    assign iu_valid_o = in_valid_i && !is_mul;
    assign mu_valid_o = in_valid_i && is_mul;

    // Ready follows the selected unit
    assign in_ready_o = is_mul ? mu_ready_i : iu_ready_i;

endmodule : eu_dispatch

`default_nettype wire

// ==== rtl/integer_unit.sv ====
// ######################################
// Single-cycle per-thread integer ALU
// with a one-entry output stream register
// ######################################

`default_nettype none

module integer_unit import gpu_eu_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,

    // Instruction in
    input  wire logic        valid_i,
    output logic             ready_o,
    input  wire iid_t        iid_i,
    input  wire eu_op_e      op_i,
    input  wire reg_idx_t    dst_i,
    input  wire act_mask_t   act_mask_i,
    input  wire warp_data_t  opa_i,
    input  wire warp_data_t  opb_i,
    input  wire tblock_idx_t tblock_idx_i,

    // Result out
    output logic             res_valid_o,
    input  wire logic        res_ready_i,
    output iid_t             res_iid_o,
    output reg_idx_t         res_dst_o,
    output act_mask_t        res_act_mask_o,
    output warp_data_t       res_data_o
);

    // ######################################
    // Per-thread ALU
    // ######################################

    // Result of one thread, a is the first operand
    function automatic reg_data_t calc_thread(
        input eu_op_e      op,
        input reg_data_t   a,
        input reg_data_t   b,
        input reg_data_t   tid,
        input iid_t        iid,
        input tblock_idx_t tblk
    );
        reg_data_t r;
        r = '0;
        case (op)
            EU_TID:           r = tid;
            EU_WID:           r = reg_data_t'(iid[WID_WIDTH-1:0]);
            EU_BID:           r = reg_data_t'(tblk);
            // Global thread index inside the block
            EU_TBID:          r = reg_data_t'(tblk) * reg_data_t'(WARP_WIDTH) + tid;
            EU_ADD, EU_ADDI:  r = b + a;
            EU_SUB, EU_SUBI:  r = b - a;
            // Immediate arrives broadcast in a
            EU_LDI, EU_OR:    r = b | a;
            EU_AND:           r = b & a;
            EU_XOR:           r = b ^ a;
            // Shift of 32 or more yields zero
            EU_SHL, EU_SHLI:  r = b << a;
            default:          r = '0;
        endcase
        return r;
    endfunction

    warp_data_t result;

    always_comb begin
        result = '0;
        for (int i = 0; i < WARP_WIDTH; i++) begin
            result[i*REG_WIDTH +: REG_WIDTH] = calc_thread(
                op_i,
                opa_i[i*REG_WIDTH +: REG_WIDTH],
                opb_i[i*REG_WIDTH +: REG_WIDTH],
                reg_data_t'(i),
                iid_i,
                tblock_idx_i
            );
        end
    end

    // ######################################
    // Output stream register
    // ######################################

    logic out_valid_q;

    // Accept when empty or being drained
    assign ready_o = !out_valid_q || res_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
        end else if (ready_o) begin
            out_valid_q <= valid_i;
        end
    end

    // Payload without reset
    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            res_iid_o      <= iid_i;
            res_dst_o      <= dst_i;
            res_act_mask_o <= act_mask_i;
            res_data_o     <= result;
        end
    end

    assign res_valid_o = out_valid_q;

endmodule : integer_unit

`default_nettype wire

// ==== rtl/multiply_unit.sv ====
// ######################################
// Three-stage per-thread 32x32 multiplier
// returning the low or the high product half
// ######################################

`default_nettype none

module multiply_unit import gpu_eu_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,

    // Instruction in
    input  wire logic       valid_i,
    output logic            ready_o,
    input  wire iid_t       iid_i,
    input  wire eu_op_e     op_i,
    input  wire reg_idx_t   dst_i,
    input  wire act_mask_t  act_mask_i,
    input  wire warp_data_t opa_i,
    input  wire warp_data_t opb_i,

    // Result out
    output logic            res_valid_o,
    input  wire logic       res_ready_i,
    output iid_t            res_iid_o,
    output reg_idx_t        res_dst_o,
    output act_mask_t       res_act_mask_o,
    output warp_data_t      res_data_o
);

    // ######################################
    // Pipeline control
    // ######################################

    logic [MUL_STAGES-1:0] stage_valid_q;
    logic                  advance;

    // Whole pipe moves when the last stage is free or taken
    assign advance = !stage_valid_q[MUL_STAGES-1] || res_ready_i;
    assign ready_o = advance;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            stage_valid_q <= '0;
        end else if (advance) begin
            stage_valid_q <= {stage_valid_q[MUL_STAGES-2:0], valid_i};
        end
    end

    // Side payload travels with each stage
    iid_t      iid_q  [MUL_STAGES];
    reg_idx_t  dst_q  [MUL_STAGES];
    act_mask_t mask_q [MUL_STAGES];

    always_ff @(posedge clk_i) begin
        if (advance) begin
            iid_q[0]  <= iid_i;
            dst_q[0]  <= dst_i;
            mask_q[0] <= act_mask_i;
            for (int s = 1; s < MUL_STAGES; s++) begin
                iid_q[s]  <= iid_q[s-1];
                dst_q[s]  <= dst_q[s-1];
                mask_q[s] <= mask_q[s-1];
            end
        end
    end

    // ######################################
    // Datapath
    // ######################################

    warp_data_t             opa_s1, opb_s1;
    logic                   hi_s1, hi_s2;
    logic [2*REG_WIDTH-1:0] prod_s2 [WARP_WIDTH];
    warp_data_t             res_s3;

    always_ff @(posedge clk_i) begin
        if (advance) begin
            // Stage 1 operands and half select
            opa_s1 <= opa_i;
            opb_s1 <= opb_i;
            hi_s1  <= (op_i == EU_MULHU);
            // Stage 2 full unsigned products
            hi_s2  <= hi_s1;
            for (int i = 0; i < WARP_WIDTH; i++) begin
                prod_s2[i] <= (2*REG_WIDTH)'(opa_s1[i*REG_WIDTH +: REG_WIDTH])
                            * (2*REG_WIDTH)'(opb_s1[i*REG_WIDTH +: REG_WIDTH]);
            end
            // Stage 3 pick the half
            for (int i = 0; i < WARP_WIDTH; i++) begin
                res_s3[i*REG_WIDTH +: REG_WIDTH] <= hi_s2
                    ? prod_s2[i][2*REG_WIDTH-1:REG_WIDTH]
                    : prod_s2[i][REG_WIDTH-1:0];
            end
        end
    end

    assign res_valid_o    = stage_valid_q[MUL_STAGES-1];
    assign res_iid_o      = iid_q[MUL_STAGES-1];
    assign res_dst_o      = dst_q[MUL_STAGES-1];
    assign res_act_mask_o = mask_q[MUL_STAGES-1];
    assign res_data_o     = res_s3;

endmodule : multiply_unit

`default_nettype wire

// ==== rtl/result_arbiter.sv ====
// ######################################
// Round-robin merge of two result streams
// into one registered write-back port
// ######################################

`default_nettype none

module result_arbiter import gpu_eu_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,

    // Source a, the integer unit
    input  wire logic       a_valid_i,
    input  wire iid_t       a_iid_i,
    input  wire reg_idx_t   a_dst_i,
    input  wire act_mask_t  a_act_mask_i,
    input  wire warp_data_t a_data_i,
    output logic            a_ready_o,

    // Source b, the multiply unit
    input  wire logic       b_valid_i,
    input  wire iid_t       b_iid_i,
    input  wire reg_idx_t   b_dst_i,
    input  wire act_mask_t  b_act_mask_i,
    input  wire warp_data_t b_data_i,
    output logic            b_ready_o,

    // Write-back port
    output logic            out_valid_o,
    output iid_t            out_iid_o,
    output reg_idx_t        out_dst_o,
    output act_mask_t       out_act_mask_o,
    output warp_data_t      out_data_o,
    input  wire logic       out_ready_i
);

    // ######################################
    // Grant
    // ######################################

    logic load;
    logic last_b_q;
    logic grant_a, grant_b;

    // Output slot free or draining this cycle
    assign load = !out_valid_o || out_ready_i;

    // On a tie serve the side not served last
    assign grant_a = a_valid_i && (!b_valid_i || last_b_q);
    assign grant_b = b_valid_i && !grant_a;

    assign a_ready_o = load && grant_a;
    assign b_ready_o = load && grant_b;

    // ######################################
    // Output register
    // ######################################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // Starts as if b was served last
            last_b_q    <= 1'b1;
            out_valid_o <= 1'b0;
        end else if (load) begin
            out_valid_o <= grant_a || grant_b;
            if (grant_a || grant_b) begin
                last_b_q <= grant_b;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load && (grant_a || grant_b)) begin
            out_iid_o      <= grant_a ? a_iid_i      : b_iid_i;
            out_dst_o      <= grant_a ? a_dst_i      : b_dst_i;
            out_act_mask_o <= grant_a ? a_act_mask_i : b_act_mask_i;
            out_data_o     <= grant_a ? a_data_i     : b_data_i;
        end
    end

endmodule : result_arbiter

`default_nettype wire

// ==== rtl/execution_cluster.sv ====
// ######################################
// Execution cluster top with dispatch, two units
// and the write-back arbiter
// ######################################

`default_nettype none

module execution_cluster import gpu_eu_pkg::*; (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,

    // Issue stream
    input  wire logic                 in_valid_i,
    output logic                      in_ready_o,
    input  wire iid_t                 in_iid_i,
    input  wire eu_op_e               in_op_i,
    input  wire reg_idx_t             in_dst_i,
    input  wire act_mask_t            in_act_mask_i,
    input  wire warp_data_t           in_opa_i,
    input  wire warp_data_t           in_opb_i,

    // Result stream to the register file
    output logic                      out_valid_o,
    input  wire logic                 out_ready_i,
    output iid_t                      out_iid_o,
    output reg_idx_t                  out_dst_o,
    output act_mask_t                 out_act_mask_o,
    output warp_data_t                out_data_o,

    // Thread-block table writes
    input  wire logic                 cfg_we_i,
    input  wire logic [WID_WIDTH-1:0] cfg_wid_i,
    input  wire tblock_idx_t          cfg_tblock_idx_i
);

    // Dispatch to units
    logic        iu_valid, iu_ready;
    logic        mu_valid, mu_ready;
    tblock_idx_t iu_tblock_idx;

    // Units to arbiter
    logic        iu_res_valid, iu_res_ready;
    iid_t        iu_res_iid;
    reg_idx_t    iu_res_dst;
    act_mask_t   iu_res_act_mask;
    warp_data_t  iu_res_data;
    logic        mu_res_valid, mu_res_ready;
    iid_t        mu_res_iid;
    reg_idx_t    mu_res_dst;
    act_mask_t   mu_res_act_mask;
    warp_data_t  mu_res_data;

    eu_dispatch u_dispatch (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .cfg_we_i(cfg_we_i), .cfg_wid_i(cfg_wid_i), .cfg_tblock_idx_i(cfg_tblock_idx_i),
        .in_valid_i(in_valid_i), .in_iid_i(in_iid_i), .in_op_i(in_op_i),
        .in_ready_o(in_ready_o),
        .iu_valid_o(iu_valid), .iu_tblock_idx_o(iu_tblock_idx), .iu_ready_i(iu_ready),
        .mu_valid_o(mu_valid), .mu_ready_i(mu_ready)
    );

    // Payload goes straight from the issue port to both units
    integer_unit u_integer_unit (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .valid_i(iu_valid), .ready_o(iu_ready),
        .iid_i(in_iid_i), .op_i(in_op_i), .dst_i(in_dst_i), .act_mask_i(in_act_mask_i),
        .opa_i(in_opa_i), .opb_i(in_opb_i), .tblock_idx_i(iu_tblock_idx),
        .res_valid_o(iu_res_valid), .res_ready_i(iu_res_ready),
        .res_iid_o(iu_res_iid), .res_dst_o(iu_res_dst),
        .res_act_mask_o(iu_res_act_mask), .res_data_o(iu_res_data)
    );

    multiply_unit u_multiply_unit (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .valid_i(mu_valid), .ready_o(mu_ready),
        .iid_i(in_iid_i), .op_i(in_op_i), .dst_i(in_dst_i), .act_mask_i(in_act_mask_i),
        .opa_i(in_opa_i), .opb_i(in_opb_i),
        .res_valid_o(mu_res_valid), .res_ready_i(mu_res_ready),
        .res_iid_o(mu_res_iid), .res_dst_o(mu_res_dst),
        .res_act_mask_o(mu_res_act_mask), .res_data_o(mu_res_data)
    );

    // Integer unit on side a so it wins the first tie
    result_arbiter u_result_arbiter (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .a_valid_i(iu_res_valid), .a_iid_i(iu_res_iid), .a_dst_i(iu_res_dst),
        .a_act_mask_i(iu_res_act_mask), .a_data_i(iu_res_data), .a_ready_o(iu_res_ready),
        .b_valid_i(mu_res_valid), .b_iid_i(mu_res_iid), .b_dst_i(mu_res_dst),
        .b_act_mask_i(mu_res_act_mask), .b_data_i(mu_res_data), .b_ready_o(mu_res_ready),
        .out_valid_o(out_valid_o), .out_iid_o(out_iid_o), .out_dst_o(out_dst_o),
        .out_act_mask_o(out_act_mask_o), .out_data_o(out_data_o),
        .out_ready_i(out_ready_i)
    );

endmodule : execution_cluster

`default_nettype wire

// ==== bench/tb_execution_cluster.sv ====
// ######################################
// Directed testbench for the execution cluster
// with a reference model keyed by iid
// ######################################

`default_nettype none

module tb_execution_cluster import gpu_eu_pkg::*; ();

    // Ops issued over all tests for the watchdog limit
    localparam int TOTAL_OPS  = 1 + 32 + 40 + 20 + 48;
    localparam int RDY_ALWAYS = 0;
    localparam int RDY_HOLD   = 1;
    localparam int RDY_RANDOM = 2;

    logic                 clk_i, rst_n_i;
    logic                 in_valid_i, in_ready_o;
    iid_t                 in_iid_i;
    eu_op_e               in_op_i;
    reg_idx_t             in_dst_i;
    act_mask_t            in_act_mask_i;
    warp_data_t           in_opa_i, in_opb_i;
    logic                 out_valid_o, out_ready_i;
    iid_t                 out_iid_o;
    reg_idx_t             out_dst_o;
    act_mask_t            out_act_mask_o;
    warp_data_t           out_data_o;
    logic                 cfg_we_i;
    logic [WID_WIDTH-1:0] cfg_wid_i;
    tblock_idx_t          cfg_tblock_idx_i;

    execution_cluster u_execution_cluster (.*);

    // ######################################
    // Reference model state
    // ######################################

    warp_data_t  exp_data [64];
    act_mask_t   exp_mask [64];
    reg_idx_t    exp_dst  [64];
    bit          exp_pend [64];
    bit          exp_mul  [64];
    iid_t        int_order[$];
    iid_t        mul_order[$];
    tblock_idx_t tbl_model [NUM_WARPS];
    int          issued_cnt = 0;
    int          done_cnt = 0;
    int          ready_mode = RDY_ALWAYS;
    int          seed = 32'h3211;
    int          ready_seed = 32'h3211;
    string       test_name = "init";

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic check_value(input string what, input warp_data_t exp_v,
                               input warp_data_t act_v);
        if (exp_v !== act_v) begin
            $display("CHECK FAILED test=%s %s expected=%0h actual=%0h",
                     test_name, what, exp_v, act_v);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Expected per-thread results of one warp
    function automatic warp_data_t model_result(input eu_op_e op, input warp_data_t a,
                                                input warp_data_t b, input reg_data_t wid,
                                                input tblock_idx_t tblk);
        warp_data_t  r;
        reg_data_t   x, y, t;
        logic [63:0] p;
        r = '0;
        for (int i = 0; i < WARP_WIDTH; i++) begin
            x = a[i*REG_WIDTH +: REG_WIDTH];
            y = b[i*REG_WIDTH +: REG_WIDTH];
            p = {32'b0, x} * {32'b0, y};
            case (op)
                EU_TID:          t = reg_data_t'(i);
                EU_WID:          t = wid;
                EU_BID:          t = reg_data_t'(tblk);
                EU_TBID:         t = reg_data_t'(tblk) * 32'd4 + reg_data_t'(i);
                EU_ADD, EU_ADDI: t = y + x;
                EU_SUB, EU_SUBI: t = y - x;
                EU_LDI, EU_OR:   t = y | x;
                EU_AND:          t = y & x;
                EU_XOR:          t = y ^ x;
                EU_SHL, EU_SHLI: t = (x >= 32'd32) ? '0 : (y << x[4:0]);
                EU_MUL:          t = p[31:0];
                EU_MULHU:        t = p[63:32];
                default:         t = '0;
            endcase
            r[i*REG_WIDTH +: REG_WIDTH] = t;
        end
        return r;
    endfunction

    function automatic warp_data_t rand_warp();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // Shift amounts 0 to 63 with about half out of range
    function automatic warp_data_t rand_shift();
        warp_data_t r;
        for (int i = 0; i < WARP_WIDTH; i++) begin
            r[i*REG_WIDTH +: REG_WIDTH] = reg_data_t'($unsigned($random(seed)) % 64);
        end
        return r;
    endfunction

    // ######################################
    // Stimulus helpers
    // ######################################

    task automatic next_cycle();
        @(posedge clk_i);
        #10;
    endtask

    // Starts 10 after an edge and returns 10 after the accepting edge
    task automatic issue_op(input iid_t iid, input eu_op_e op, input act_mask_t mask,
                            input warp_data_t a, input warp_data_t b);
        in_valid_i    = 1'b1;
        in_iid_i      = iid;
        in_op_i       = op;
        in_dst_i      = {2'b10, iid};
        in_act_mask_i = mask;
        in_opa_i      = a;
        in_opb_i      = b;
        do @(posedge clk_i); while (!in_ready_o);
        exp_data[iid] = model_result(op, a, b, reg_data_t'(iid[WID_WIDTH-1:0]),
                                     tbl_model[iid[WID_WIDTH-1:0]]);
        exp_mask[iid] = mask;
        exp_dst[iid]  = {2'b10, iid};
        exp_pend[iid] = 1'b1;
        exp_mul[iid]  = (op == EU_MUL) || (op == EU_MULHU);
        if (exp_mul[iid]) mul_order.push_back(iid);
        else int_order.push_back(iid);
        issued_cnt++;
        #10;
        in_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        do @(negedge clk_i); while (done_cnt != issued_cnt);
    endtask

    // Write-back ready driver and first stall detection
    initial begin : ready_driver
        int mode;
        out_ready_i = 1'b1;
        forever begin
            @(posedge clk_i);
            if (ready_mode == RDY_HOLD && in_valid_i && !in_ready_o) ready_mode = RDY_RANDOM;
            mode = ready_mode;
            #10;
            if (mode == RDY_HOLD) out_ready_i = 1'b0;
            else if (mode == RDY_RANDOM) out_ready_i = 1'($random(ready_seed));
            else out_ready_i = 1'b1;
        end
    end

    // ######################################
    // Result collector
    // ######################################

    always @(posedge clk_i) begin : collect
        iid_t want;
        if (rst_n_i && out_valid_o && out_ready_i) begin
            if (!exp_pend[out_iid_o]) begin
                $display("ERROR: test %s got iid %0d that was not issued or came twice",
                         test_name, out_iid_o);
                $display("TEST FAIL");
                $fatal(1, "unexpected result");
            end else begin
                if (exp_mul[out_iid_o]) want = mul_order.pop_front();
                else want = int_order.pop_front();
                check_value("unit order", warp_data_t'(want), warp_data_t'(out_iid_o));
                check_value("dst", warp_data_t'(exp_dst[out_iid_o]), warp_data_t'(out_dst_o));
                check_value("mask", warp_data_t'(exp_mask[out_iid_o]),
                            warp_data_t'(out_act_mask_o));
                check_value("data", exp_data[out_iid_o], out_data_o);
                exp_pend[out_iid_o] = 1'b0;
                done_cnt++;
            end
        end
    end

    // ######################################
    // Tests
    // ######################################

    task automatic test_reset_state();
        test_name = "test_reset_state";
        repeat (4) begin
            @(negedge clk_i);
            check_value("out_valid", '0, warp_data_t'(out_valid_o));
        end
        next_cycle();
        // Table still all zero
        issue_op(iid_t'(0), EU_BID, 4'b1111, rand_warp(), rand_warp());
        wait_drain();
    endtask

    task automatic test_identity();
        test_name = "test_identity";
        next_cycle();
        for (int w = 0; w < NUM_WARPS; w++) begin
            cfg_we_i         = 1'b1;
            cfg_wid_i        = WID_WIDTH'(w);
            cfg_tblock_idx_i = tblock_idx_t'((w * 5 + 3) % 16);
            next_cycle();
            tbl_model[w] = tblock_idx_t'((w * 5 + 3) % 16);
        end
        cfg_we_i = 1'b0;
        for (int k = 0; k < 4; k++) begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                issue_op(iid_t'(k * 8 + w), eu_op_e'(int'(EU_TID) + k),
                         act_mask_t'($random(seed)), rand_warp(), rand_warp());
            end
        end
        wait_drain();
    endtask

    task automatic test_alu();
        eu_op_e     op;
        reg_data_t  imm;
        warp_data_t a;
        test_name = "test_alu";
        next_cycle();
        for (int n = 0; n < 40; n++) begin
            op  = eu_op_e'(int'(EU_ADD) + n % 10);
            imm = (op == EU_SHLI) ? reg_data_t'($unsigned($random(seed)) % 64)
                                  : reg_data_t'($random(seed));
            case (op)
                EU_ADDI, EU_SUBI, EU_LDI, EU_SHLI: a = {WARP_WIDTH{imm}};
                EU_SHL:  a = rand_shift();
                default: a = rand_warp();
            endcase
            issue_op(iid_t'(n), op, act_mask_t'($random(seed)), a, rand_warp());
        end
        wait_drain();
    endtask

    task automatic test_multiply();
        warp_data_t ones;
        ones = '1;
        test_name = "test_multiply";
        next_cycle();
        for (int n = 0; n < 16; n++) begin
            issue_op(iid_t'(n), (n % 2 == 1) ? EU_MULHU : EU_MUL,
                     act_mask_t'($random(seed)), rand_warp(), rand_warp());
        end
        // Corner products with all-ones operands
        issue_op(iid_t'(16), EU_MUL, 4'b1111, ones, ones);
        issue_op(iid_t'(17), EU_MULHU, 4'b0101, ones, ones);
        issue_op(iid_t'(18), EU_MUL, 4'b1010, ones, rand_warp());
        issue_op(iid_t'(19), EU_MULHU, 4'b0011, ones, rand_warp());
        wait_drain();
    endtask

    task automatic test_backpressure();
        eu_op_e op;
        test_name = "test_backpressure";
        next_cycle();
        // Held low until issue stalls and toggled after that
        ready_mode = RDY_HOLD;
        for (int n = 0; n < 48; n++) begin
            if (n % 3 == 2) op = (n % 2 == 1) ? EU_MULHU : EU_MUL;
            else op = eu_op_e'($unsigned($random(seed)) % 14);
            issue_op(iid_t'(n), op, act_mask_t'($random(seed)), rand_shift(), rand_warp());
        end
        wait_drain();
        ready_mode = RDY_ALWAYS;
    endtask

    // ######################################
    // Main sequence and watchdog
    // ######################################

    initial begin
        rst_n_i          = 1'b0;
        in_valid_i       = 1'b0;
        in_iid_i         = '0;
        in_op_i          = EU_TID;
        in_dst_i         = '0;
        in_act_mask_i    = '0;
        in_opa_i         = '0;
        in_opb_i         = '0;
        cfg_we_i         = 1'b0;
        cfg_wid_i        = '0;
        cfg_tblock_idx_i = '0;
        for (int w = 0; w < NUM_WARPS; w++) tbl_model[w] = '0;
        repeat (5) @(posedge clk_i);
        #10;
        rst_n_i = 1'b1;
        test_reset_state();
        test_identity();
        test_alu();
        test_multiply();
        test_backpressure();
        if (issued_cnt == done_cnt && int_order.size() == 0 && mul_order.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("ERROR: %0d issued but %0d results returned", issued_cnt, done_cnt);
            $display("TEST FAIL");
            $fatal(1, "model not empty");
        end
    end

    initial begin
        repeat (TOTAL_OPS * (MUL_STAGES + 10)) @(posedge clk_i);
        $display("ERROR: watchdog timeout in %s, %0d of %0d results returned",
                 test_name, done_cnt, issued_cnt);
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

endmodule : tb_execution_cluster

`default_nettype wire

// ==== flist.f ====
rtl/gpu_eu_pkg.sv
rtl/eu_dispatch.sv
rtl/integer_unit.sv
rtl/multiply_unit.sv
rtl/result_arbiter.sv
rtl/execution_cluster.sv
bench/tb_execution_cluster.sv

// ==== Makefile ====
# Verilator build and run of the execution cluster testbench

all: run

run:
	verilator --binary --timing -f flist.f --top-module tb_execution_cluster \
		-Mdir obj_dir -o sim_tb
	@out="$$(./obj_dir/sim_tb)"; echo "$$out"; echo "$$out" | grep -q "^TEST PASS$$"

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module execution_cluster

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
